// ==== uncore_config.svh ====
// ----------------------------------------------------------
// Constants for the uncore MMIO counter region.
// Included by the APB front end and the counter block.
// ----------------------------------------------------------
`ifndef UNCORE_CONFIG_SVH
`define UNCORE_CONFIG_SVH

`define UNCORE_MMIO_BASE_ADDR   32'h0000_1000 // Base of counter region
`define UNCORE_MMIO_BASE_MASK   32'hFFFF_F000 // Address bits that pick the region

// Register offsets within the region
`define UNCORE_OFS_MTIME_LO     12'h000       // Time low word
`define UNCORE_OFS_MTIME_HI     12'h004       // Time high word
`define UNCORE_OFS_MTIMECMP_LO  12'h008       // Time compare low word
`define UNCORE_OFS_MTIMECMP_HI  12'h00C       // Time compare high word
`define UNCORE_OFS_INHIBIT      12'h010       // Counter inhibit, 3 bits
`define UNCORE_OFS_CYCLE_LO     12'h014       // Read only
`define UNCORE_OFS_INSTRET_LO   12'h018       // Read only

`define UNCORE_INH_CYCLE        0             // Inhibit bit for cycle
`define UNCORE_INH_TIME         1             // Inhibit bit for time
`define UNCORE_INH_INSTRET      2             // Inhibit bit for instret

`endif

// ==== uncore_pkg.sv ====
// ----------------------------------------------------------
// Shared packed struct types of the uncore.
// Bus, MMIO, interrupt and counter bundles live here.
// ----------------------------------------------------------
`default_nettype none

package uncore_pkg;

  // ---------------------------------------------------------
  // APB slave port
  typedef struct packed {
    logic [31:0] paddr;     // Byte address
    logic        psel;      // Slave selected
    logic        penable;   // High in access phase
    logic        pwrite;    // Write transfer
    logic [31:0] pwdata;    // Write data
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;    // Read data, valid with pready
    logic        pready;    // Access phase completes
    logic        pslverr;   // Transfer failed
  } apb_rsp_t;

  // ---------------------------------------------------------
  // Decode to counter block
  typedef struct packed {
    logic        en;        // Access cycle inside region
    logic        wen;       // Write access
    logic [11:0] offset;    // Offset within region
    logic [31:0] wdata;     // Write data
  } mmio_req_t;

  typedef struct packed {
    logic [31:0] rdata;     // Zero on unmapped offset
    logic        error;     // Unmapped or read only write
  } mmio_rsp_t;

  // ---------------------------------------------------------
  // Interrupts
  typedef struct packed {
    logic        nmi;       // Non-maskable line
    logic        external;  // External line
    logic [3:0]  ext_cause; // External cause code
    logic        software;  // Software line
  } irq_lines_t;

  typedef struct packed {
    logic mie;              // Global enable
    logic meie;             // External enable
    logic mtie;             // Timer enable
    logic msie;             // Software enable
  } irq_enable_t;

  typedef struct packed {
    logic meip;             // External pending
    logic mtip;             // Timer pending
    logic msip;             // Software pending
  } mip_t;

  typedef struct packed {
    logic       req;        // Trap wanted
    logic [5:0] cause;      // Held while req is high
  } trap_req_t;

  // Counter values seen by the pipeline
  typedef struct packed {
    logic [63:0] mtime;     // Real time counter
    logic [63:0] cycle;     // Clock cycles
    logic [63:0] instret;   // Retired instructions
  } counters_t;

endpackage

`default_nettype wire

// ==== mmio_decode.sv ====
// ----------------------------------------------------------
// APB slave front end for the counter region.
// Checks the region and hands an MMIO request to the counters.
// Zero wait states, every transfer takes two cycles.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uncore_config.svh"

module mmio_decode (
  input  wire                   g_clk,    // Global clock
  input  wire                   rst,      // Active high sync reset
  input  wire uncore_pkg::apb_req_t  apb_req,  // From APB master
  output uncore_pkg::apb_rsp_t  apb_rsp,  // To APB master
  output uncore_pkg::mmio_req_t mmio_req, // To counter block
  input  wire uncore_pkg::mmio_rsp_t mmio_rsp  // From counter block
);

  logic setup;      // Setup phase seen this cycle
  logic setup_q;    // Previous cycle was setup
  logic access;     // Access phase after a setup
  logic hit;        // Address inside region

  // ---------------------------------------------------------
  // Phase tracking

  assign setup  = apb_req.psel & ~apb_req.penable;
  assign access = apb_req.psel & apb_req.penable & setup_q; // Only one access per setup

  always_ff @(posedge g_clk) begin
    if (rst) begin
      setup_q <= 1'b0;
    end else begin
      setup_q <= setup;               // Arms the next cycle
    end
  end

  // Region compare on the upper address bits
  assign hit = (apb_req.paddr & `UNCORE_MMIO_BASE_MASK) == `UNCORE_MMIO_BASE_ADDR;

  // ---------------------------------------------------------
  // Request to counters

  always_comb begin
    mmio_req.en     = access & hit;         // Writes land on edge ending access
    mmio_req.wen    = apb_req.pwrite;
    mmio_req.offset = apb_req.paddr[11:0];  // Byte offset in region
    mmio_req.wdata  = apb_req.pwdata;
  end

  // ---------------------------------------------------------
  // APB response

  always_comb begin
    apb_rsp.pready  = access;               // No wait states
    apb_rsp.pslverr = access & (~hit | mmio_rsp.error);
    if (access && hit && !mmio_rsp.error && !apb_req.pwrite) begin
      apb_rsp.prdata = mmio_rsp.rdata;
    end else begin
      apb_rsp.prdata = 32'h0;               // Failed or idle reads give zero
    end
  end

endmodule

`default_nettype wire

// ==== core_counters.sv ====
// ----------------------------------------------------------
// Time, cycle and instret counters with time compare.
// Registers are reached through the MMIO request from decode.
// Raises timer pending while time >= time compare.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uncore_config.svh"

module core_counters (
  input  wire                   g_clk,      // Global clock
  input  wire                   rst,        // Active high sync reset
  input  wire uncore_pkg::mmio_req_t mmio_req,   // From decode
  output uncore_pkg::mmio_rsp_t mmio_rsp,   // Back to decode
  input  wire                   instr_ret,  // One pulse per retired instr
  output logic                  ti_pending, // Timer interrupt condition
  output uncore_pkg::counters_t ctrs        // Values for the pipeline
);

  logic [63:0] time_q;      // Real time counter
  logic [63:0] cycle_q;     // Cycle counter
  logic [63:0] instret_q;   // Retired instruction counter
  logic [63:0] cmp_q;       // Time compare
  logic [2:0]  inhibit_q;   // Per counter stop bits

  logic        mapped;      // Offset hits a register
  logic        rd_only;     // Offset cannot be written
  logic        wr_ok;       // Write passes all checks
  logic        wr_time_lo;  // Time low write
  logic        wr_time_hi;  // Time high write
  logic        wr_cmp_lo;   // Compare low write
  logic        wr_cmp_hi;   // Compare high write
  logic        wr_inh;      // Inhibit write

  // ---------------------------------------------------------
  // Read mux and access checks

  always_comb begin
    mapped         = 1'b1;
    rd_only        = 1'b0;
    mmio_rsp.rdata = 32'h0;
    case (mmio_req.offset)
      `UNCORE_OFS_MTIME_LO:    mmio_rsp.rdata = time_q[31:0];
      `UNCORE_OFS_MTIME_HI:    mmio_rsp.rdata = time_q[63:32];
      `UNCORE_OFS_MTIMECMP_LO: mmio_rsp.rdata = cmp_q[31:0];
      `UNCORE_OFS_MTIMECMP_HI: mmio_rsp.rdata = cmp_q[63:32];
      `UNCORE_OFS_INHIBIT:     mmio_rsp.rdata = {29'h0, inhibit_q};
      `UNCORE_OFS_CYCLE_LO: begin
        mmio_rsp.rdata = cycle_q[31:0];
        rd_only        = 1'b1;
      end
      `UNCORE_OFS_INSTRET_LO: begin
        mmio_rsp.rdata = instret_q[31:0];
        rd_only        = 1'b1;
      end
      default: begin
        mapped = 1'b0;                    // Reads back as zero
      end
    endcase
    mmio_rsp.error = mmio_req.en & (~mapped | (mmio_req.wen & rd_only));
  end

  assign wr_ok      = mmio_req.en & mmio_req.wen & ~mmio_rsp.error;
  assign wr_time_lo = wr_ok & (mmio_req.offset == `UNCORE_OFS_MTIME_LO);
  assign wr_time_hi = wr_ok & (mmio_req.offset == `UNCORE_OFS_MTIME_HI);
  assign wr_cmp_lo  = wr_ok & (mmio_req.offset == `UNCORE_OFS_MTIMECMP_LO);
  assign wr_cmp_hi  = wr_ok & (mmio_req.offset == `UNCORE_OFS_MTIMECMP_HI);
  assign wr_inh     = wr_ok & (mmio_req.offset == `UNCORE_OFS_INHIBIT);

  // ---------------------------------------------------------
  // Counters

  always_ff @(posedge g_clk) begin
    if (rst) begin
      time_q <= 64'h0;
    end else if (wr_time_lo) begin
      time_q <= {time_q[63:32], mmio_req.wdata};  // Write replaces the increment
    end else if (wr_time_hi) begin
      time_q <= {mmio_req.wdata, time_q[31:0]};
    end else if (!inhibit_q[`UNCORE_INH_TIME]) begin
      time_q <= time_q + 64'd1;
    end
  end

  always_ff @(posedge g_clk) begin
    if (rst) begin
      cycle_q   <= 64'h0;
      instret_q <= 64'h0;
    end else begin
      if (!inhibit_q[`UNCORE_INH_CYCLE]) begin
        cycle_q <= cycle_q + 64'd1;
      end
      if (instr_ret && !inhibit_q[`UNCORE_INH_INSTRET]) begin
        instret_q <= instret_q + 64'd1;   // Counts retire pulses only
      end
    end
  end

  // Compare and inhibit registers
  always_ff @(posedge g_clk) begin
    if (rst) begin
      cmp_q     <= '1;                    // No timer interrupt out of reset
      inhibit_q <= 3'b000;
    end else begin
      if (wr_cmp_lo) begin
        cmp_q[31:0] <= mmio_req.wdata;
      end
      if (wr_cmp_hi) begin
        cmp_q[63:32] <= mmio_req.wdata;
      end
      if (wr_inh) begin
        inhibit_q <= mmio_req.wdata[2:0]; // Upper bits dropped
      end
    end
  end

  // ---------------------------------------------------------
  // Outputs

  assign ti_pending = time_q >= cmp_q;

  always_comb begin
    ctrs.mtime   = time_q;
    ctrs.cycle   = cycle_q;
    ctrs.instret = instret_q;
  end

endmodule

`default_nettype wire

// ==== interrupt_unit.sv ====
// ----------------------------------------------------------
// Interrupt pending latch, enable masking and trap request.
// One source is picked by fixed priority and held until the
// pipeline acknowledges it.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module interrupt_unit (
  input  wire                     g_clk,      // Global clock
  input  wire                     rst,        // Active high sync reset
  input  wire uncore_pkg::irq_lines_t  irq_lines,  // Raw interrupt lines
  input  wire uncore_pkg::irq_enable_t irq_en,     // Enables from pipeline
  input  wire                     ti_pending, // From counter block
  output uncore_pkg::mip_t        mip,        // Pending bits
  output uncore_pkg::trap_req_t   trap,       // Request to pipeline
  input  wire                     trap_ack    // Pipeline took the trap
);

  logic       nmi_q;        // Latched NMI line
  logic [3:0] ext_cause_q;  // Cause sampled with external line
  logic       ext_en;       // External pending and enabled
  logic       sw_en;        // Software pending and enabled
  logic       tm_en;        // Timer pending and enabled
  logic       any_en;       // Something wants a trap
  logic [5:0] cause_sel;    // Winner of priority pick
  logic       req_q;        // Outstanding request
  logic [5:0] cause_q;      // Cause of outstanding request

  // ---------------------------------------------------------
  // Pending bits, one cycle behind the lines

  always_ff @(posedge g_clk) begin
    if (rst) begin
      mip   <= '0;
      nmi_q <= 1'b0;
    end else begin
      mip.meip <= irq_lines.external;
      mip.mtip <= ti_pending;
      mip.msip <= irq_lines.software;
      nmi_q    <= irq_lines.nmi;
    end
  end

  always_ff @(posedge g_clk) begin
    ext_cause_q <= irq_lines.ext_cause; // Only read while meip set
  end

  // Masking
  assign ext_en = irq_en.mie & irq_en.meie & mip.meip;
  assign sw_en  = irq_en.mie & irq_en.msie & mip.msip;
  assign tm_en  = irq_en.mie & irq_en.mtie & mip.mtip;
  assign any_en = nmi_q | ext_en | sw_en | tm_en;   // NMI ignores enables

  // Fixed priority NMI, external, software, timer
  always_comb begin
    if (nmi_q) begin
      cause_sel = 6'd0;
    end else if (ext_en) begin
      cause_sel = 6'd16 + {2'b00, ext_cause_q};
    end else if (sw_en) begin
      cause_sel = 6'd3;
    end else begin
      cause_sel = 6'd7;                 // Timer
    end
  end

  // ---------------------------------------------------------
  // Request and acknowledge

  always_ff @(posedge g_clk) begin
    if (rst) begin
      req_q <= 1'b0;
    end else if (req_q) begin
      req_q <= ~trap_ack;               // Drops the cycle after ack
    end else begin
      req_q <= any_en;
    end
  end

  always_ff @(posedge g_clk) begin
    if (!req_q) begin
      cause_q <= cause_sel;             // Frozen while request is up
    end
  end

  always_comb begin
    trap.req   = req_q;
    trap.cause = cause_q;
  end

endmodule

`default_nettype wire

// ==== uncore_top.sv ====
// ----------------------------------------------------------
// Uncore top level beside the CPU pipeline.
// Wires the APB front end, counter block and interrupt unit.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module uncore_top (
  input  wire                     g_clk,      // Global clock
  input  wire                     rst,        // Active high sync reset
  input  wire uncore_pkg::apb_req_t    apb_req,    // APB request
  output uncore_pkg::apb_rsp_t    apb_rsp,    // APB response
  input  wire                     instr_ret,  // Instruction retired
  input  wire uncore_pkg::irq_lines_t  irq_lines,  // Interrupt lines
  input  wire uncore_pkg::irq_enable_t irq_en,     // Interrupt enables
  output uncore_pkg::mip_t        mip,        // Pending bits
  output uncore_pkg::trap_req_t   trap,       // Trap request
  input  wire                     trap_ack,   // Trap taken
  output logic                    int_mtime,  // Timer interrupt pending
  output uncore_pkg::counters_t   ctrs        // Counter values
);

  import uncore_pkg::*;

  mmio_req_t mmio_req;    // Decode to counters
  mmio_rsp_t mmio_rsp;    // Counters to decode
  logic      ti_pending;  // Counters to interrupt unit

  assign int_mtime = mip.mtip;

  // APB front end
  mmio_decode i_decode (
    .g_clk    (g_clk    ),
    .rst      (rst      ),
    .apb_req  (apb_req  ),
    .apb_rsp  (apb_rsp  ),
    .mmio_req (mmio_req ), // Region access request
    .mmio_rsp (mmio_rsp )  // Read data and error
  );

  // Counters and time compare
  core_counters i_counters (
    .g_clk      (g_clk      ),
    .rst        (rst        ),
    .mmio_req   (mmio_req   ),
    .mmio_rsp   (mmio_rsp   ),
    .instr_ret  (instr_ret  ), // Retire pulses from pipeline
    .ti_pending (ti_pending ), // Time reached compare
    .ctrs       (ctrs       )
  );

  // Interrupt pending and trap request
  interrupt_unit i_interrupts (
    .g_clk      (g_clk      ),
    .rst        (rst        ),
    .irq_lines  (irq_lines  ),
    .irq_en     (irq_en     ),
    .ti_pending (ti_pending ),
    .mip        (mip        ),
    .trap       (trap       ),
    .trap_ack   (trap_ack   )  // Ack from writeback
  );

endmodule

`default_nettype wire

// ==== tb_uncore.sv ====
// ----------------------------------------------------------
// Testbench for the uncore top level. Acts as the pipeline:
// APB master, retire pulses, interrupt lines, enables and
// trap acknowledge. Stops at the first failing check.
// ----------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "uncore_config.svh"

module tb_uncore;

  import uncore_pkg::*;

  localparam int CLK_PERIOD  = 20;   // ns
  localparam int TEST_CYCLES = 400;  // Rough sum of all test sections
  localparam int MARGIN      = 200;  // Slack for the watchdog
  localparam int TRAP_WAIT   = 8;    // Max cycles until a trap request

  logic        g_clk;
  logic        rst;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        instr_ret;
  irq_lines_t  irq_lines;
  irq_enable_t irq_en;
  mip_t        mip;
  trap_req_t   trap;
  logic        trap_ack;
  logic        int_mtime;
  counters_t   ctrs;

  logic [31:0] rdata;    // Last read data
  logic        err;      // Last pslverr
  logic [31:0] v0, v1, v2;
  logic [31:0] t0, t1;   // Time samples
  logic [31:0] c0, c1;   // Cycle samples
  logic [31:0] i0, i1;   // Instret samples
  logic [31:0] rnd;      // Scratch random word
  int          n_ret;    // Retire pulses driven
  int          n_cyc;

  uncore_top dut0 (
    .g_clk     (g_clk    ),
    .rst       (rst      ),
    .apb_req   (apb_req  ),
    .apb_rsp   (apb_rsp  ),
    .instr_ret (instr_ret),
    .irq_lines (irq_lines),
    .irq_en    (irq_en   ),
    .mip       (mip      ),
    .trap      (trap     ),
    .trap_ack  (trap_ack ),
    .int_mtime (int_mtime),
    .ctrs      (ctrs     )
  );

  initial g_clk = 1'b0;
  always #(CLK_PERIOD / 2) g_clk = ~g_clk;

  // Watchdog
  initial begin
    #(CLK_PERIOD * (TEST_CYCLES + MARGIN));
    $display("Watchdog expired before all tests completed");
    $display("TESTBENCH FAILED");
    $fatal(1);
  end

  // ---------------------------------------------------------
  // Check helpers

  task automatic expect_val(input string name, input logic [63:0] got,
                            input logic [63:0] exp);
    assert (got === exp) else begin
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // ---------------------------------------------------------
  // APB master, setup then access, sampled mid low phase

  task automatic apb_xfer(input logic [31:0] addr, input logic write,
                          input logic [31:0] wdata, output logic [31:0] rd,
                          output logic slverr);
    @(negedge g_clk);
    apb_req.paddr   = addr;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;                   // Setup phase
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    #(CLK_PERIOD / 4);
    expect_val("apb_rsp.pready (setup)", apb_rsp.pready, 1'b0);
    @(negedge g_clk);
    apb_req.penable = 1'b1;                   // Access phase
    #(CLK_PERIOD / 4);
    expect_val("apb_rsp.pready (access)", apb_rsp.pready, 1'b1);
    rd     = apb_rsp.prdata;
    slverr = apb_rsp.pslverr;
    @(negedge g_clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = 1'b0;
  endtask

  task automatic reg_write(input logic [11:0] ofs, input logic [31:0] data);
    logic [31:0] unused_rd;
    logic        slverr;
    apb_xfer(`UNCORE_MMIO_BASE_ADDR | {20'h0, ofs}, 1'b1, data, unused_rd, slverr);
    expect_val("apb_rsp.pslverr (write)", slverr, 1'b0);
  endtask

  task automatic reg_read(input logic [11:0] ofs, output logic [31:0] data);
    logic slverr;
    apb_xfer(`UNCORE_MMIO_BASE_ADDR | {20'h0, ofs}, 1'b0, 32'h0, data, slverr);
    expect_val("apb_rsp.pslverr (read)", slverr, 1'b0);
  endtask

  // ---------------------------------------------------------
  // Trap side

  // Waits for a request, then checks the cause holds for a few cycles
  task automatic wait_trap(input logic [5:0] exp_cause);
    int n;
    n = 0;
    while (!trap.req && n < TRAP_WAIT) begin
      @(negedge g_clk);
      n++;
    end
    expect_true(trap.req, "No trap request raised within the allowed cycles");
    expect_val("trap.cause", trap.cause, exp_cause);
    repeat (3) begin
      @(negedge g_clk);
      expect_val("trap.req (held)", trap.req, 1'b1);
      expect_val("trap.cause (held)", trap.cause, exp_cause);
    end
  endtask

  task automatic ack_trap();
    @(negedge g_clk);
    trap_ack = 1'b1;
    @(negedge g_clk);
    trap_ack = 1'b0;
    expect_val("trap.req (after ack)", trap.req, 1'b0);  // Low the cycle after
  endtask

  // ---------------------------------------------------------
  // Stimulus

  initial begin
    void'($urandom(32'hcfe43db5));
    rst       = 1'b1;
    apb_req   = '0;
    instr_ret = 1'b0;
    irq_lines = '0;
    irq_en    = '0;
    trap_ack  = 1'b0;
    repeat (8) @(negedge g_clk);
    rst = 1'b0;

    // Reset state
    #(CLK_PERIOD / 4);
    expect_val("trap.req", trap.req, 1'b0);
    expect_val("int_mtime", int_mtime, 1'b0);
    expect_val("mip", mip, 3'b000);
    expect_val("apb_rsp.pready (idle)", apb_rsp.pready, 1'b0);
    reg_read(`UNCORE_OFS_MTIMECMP_LO, rdata);
    expect_val("mtimecmp_lo", rdata, 32'hFFFF_FFFF);
    reg_read(`UNCORE_OFS_MTIMECMP_HI, rdata);
    expect_val("mtimecmp_hi", rdata, 32'hFFFF_FFFF);
    reg_read(`UNCORE_OFS_INHIBIT, rdata);
    expect_val("inhibit", rdata, 32'h0);
    #(CLK_PERIOD / 4);
    expect_val("apb_rsp.pready (idle)", apb_rsp.pready, 1'b0);

    // Register read back, inhibit keeps 3 bits
    v0 = $urandom;
    v1 = $urandom;
    v2 = $urandom;
    reg_write(`UNCORE_OFS_MTIMECMP_LO, v0);
    reg_write(`UNCORE_OFS_MTIMECMP_HI, v1);
    reg_write(`UNCORE_OFS_INHIBIT, v2);
    reg_read(`UNCORE_OFS_MTIMECMP_LO, rdata);
    expect_val("mtimecmp_lo", rdata, v0);
    reg_read(`UNCORE_OFS_MTIMECMP_HI, rdata);
    expect_val("mtimecmp_hi", rdata, v1);
    reg_read(`UNCORE_OFS_INHIBIT, rdata);
    expect_val("inhibit", rdata, {29'h0, v2[2:0]});

    // Outside the region, same low bits as time compare
    apb_xfer(32'h0000_2008, 1'b0, 32'h0, rdata, err);
    expect_val("apb_rsp.pslverr (outside read)", err, 1'b1);
    expect_val("apb_rsp.prdata (outside read)", rdata, 32'h0);
    apb_xfer(32'h0000_2008, 1'b1, ~v0, rdata, err);
    expect_val("apb_rsp.pslverr (outside write)", err, 1'b1);
    reg_read(`UNCORE_OFS_MTIMECMP_LO, rdata);
    expect_val("mtimecmp_lo", rdata, v0);

    // Read-only cycle and unmapped offset
    reg_write(`UNCORE_OFS_INHIBIT, 32'h1 << `UNCORE_INH_CYCLE);
    reg_read(`UNCORE_OFS_CYCLE_LO, c0);
    apb_xfer(`UNCORE_MMIO_BASE_ADDR | `UNCORE_OFS_CYCLE_LO, 1'b1, $urandom, rdata, err);
    expect_val("apb_rsp.pslverr (cycle write)", err, 1'b1);
    reg_read(`UNCORE_OFS_CYCLE_LO, c1);
    expect_val("cycle_lo", c1, c0);
    apb_xfer(`UNCORE_MMIO_BASE_ADDR | 32'h01C, 1'b1, $urandom, rdata, err);
    expect_val("apb_rsp.pslverr (unmapped write)", err, 1'b1);
    apb_xfer(`UNCORE_MMIO_BASE_ADDR | 32'h01C, 1'b0, 32'h0, rdata, err);
    expect_val("apb_rsp.pslverr (unmapped read)", err, 1'b1);
    expect_val("apb_rsp.prdata (unmapped read)", rdata, 32'h0);
    reg_read(`UNCORE_OFS_MTIMECMP_HI, rdata);
    expect_val("mtimecmp_hi", rdata, v1);
    reg_read(`UNCORE_OFS_INHIBIT, rdata);
    expect_val("inhibit", rdata, 32'h1);

    // Counting with cycle and time stopped
    reg_write(`UNCORE_OFS_INHIBIT, 32'h3);
    reg_read(`UNCORE_OFS_MTIME_LO, t0);
    reg_read(`UNCORE_OFS_CYCLE_LO, c0);
    repeat (4) @(negedge g_clk);
    reg_read(`UNCORE_OFS_MTIME_LO, t1);
    expect_val("mtime_lo (inhibited)", t1, t0);
    reg_read(`UNCORE_OFS_CYCLE_LO, c1);
    expect_val("cycle_lo (inhibited)", c1, c0);
    reg_read(`UNCORE_OFS_INSTRET_LO, i0);
    n_ret = 0;
    n_cyc = 8 + ($urandom % 16);
    repeat (n_cyc) begin
      @(negedge g_clk);
      rnd       = $urandom;
      instr_ret = rnd[0];                    // Random retire pattern
      if (rnd[0]) n_ret++;
    end
    @(negedge g_clk);
    instr_ret = 1'b0;
    reg_read(`UNCORE_OFS_INSTRET_LO, i1);
    expect_val("instret delta", i1 - i0, n_ret);
    expect_val("ctrs.instret", ctrs.instret, n_ret);  // No retires before this section
    expect_val("ctrs.cycle (inhibited)", ctrs.cycle, {32'h0, c0});
    reg_write(`UNCORE_OFS_INHIBIT, 32'h0);
    reg_read(`UNCORE_OFS_CYCLE_LO, c0);
    reg_read(`UNCORE_OFS_CYCLE_LO, c1);
    expect_true(c1 > c0, "Cycle counter did not grow after the inhibit was cleared");

    // Timer interrupt with time held
    reg_write(`UNCORE_OFS_INHIBIT, 32'h1 << `UNCORE_INH_TIME);
    t0 = ($urandom & 32'h7FFF_FFFF) | 32'h100;
    reg_write(`UNCORE_OFS_MTIME_HI, 32'h0);
    reg_write(`UNCORE_OFS_MTIME_LO, t0);
    reg_read(`UNCORE_OFS_MTIME_LO, t1);
    expect_val("mtime_lo", t1, t0);
    expect_val("ctrs.mtime", ctrs.mtime, {32'h0, t0});
    reg_write(`UNCORE_OFS_MTIMECMP_HI, 32'h0);
    reg_write(`UNCORE_OFS_MTIMECMP_LO, t0 - 32'd1);
    @(negedge g_clk);                        // mip lags one cycle
    expect_val("int_mtime", int_mtime, 1'b1);
    expect_val("mip.mtip", mip.mtip, 1'b1);
    reg_write(`UNCORE_OFS_MTIMECMP_LO, 32'hFFFF_FFFF);
    reg_write(`UNCORE_OFS_MTIMECMP_HI, 32'hFFFF_FFFF);
    @(negedge g_clk);
    expect_val("int_mtime", int_mtime, 1'b0);
    expect_val("mip.mtip", mip.mtip, 1'b0);
    reg_write(`UNCORE_OFS_MTIMECMP_LO, t0 - 32'd1);
    reg_write(`UNCORE_OFS_MTIMECMP_HI, 32'h0);
    irq_en.mie  = 1'b1;
    irq_en.mtie = 1'b1;
    wait_trap(6'd7);
    irq_en = '0;                             // Request must hold anyway
    ack_trap();
    reg_write(`UNCORE_OFS_MTIMECMP_LO, 32'hFFFF_FFFF);
    reg_write(`UNCORE_OFS_MTIMECMP_HI, 32'hFFFF_FFFF);
    expect_val("trap.req (timer masked)", trap.req, 1'b0);

    // External beats software
    irq_en = '1;
    rnd    = $urandom;
    irq_lines.software  = 1'b1;
    irq_lines.external  = 1'b1;
    irq_lines.ext_cause = rnd[3:0];
    wait_trap({2'b01, rnd[3:0]});            // 16 plus ext_cause
    expect_val("mip.meip", mip.meip, 1'b1);
    expect_val("mip.msip", mip.msip, 1'b1);
    irq_lines.external = 1'b0;
    ack_trap();
    wait_trap(6'd3);
    irq_lines.software = 1'b0;
    ack_trap();

    // Global enable clear, only NMI gets through
    irq_en     = '1;
    irq_en.mie = 1'b0;
    irq_lines.software = 1'b1;
    irq_lines.external = 1'b1;
    repeat (4) begin
      @(negedge g_clk);
      expect_val("trap.req (global off)", trap.req, 1'b0);
    end
    irq_lines.nmi = 1'b1;
    wait_trap(6'd0);
    irq_lines = '0;
    ack_trap();
    @(negedge g_clk);
    expect_val("trap.req (idle)", trap.req, 1'b0);

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
uncore_pkg.sv
mmio_decode.sv
core_counters.sv
interrupt_unit.sv
uncore_top.sv
tb_uncore.sv
